// File: verilog/noise_est_defines.svh
// Widths, block size and FIFO depth for the noise estimator.
// Include this in any file that sizes a signal from these values.

`ifndef NOISE_EST_DEFINES_SVH
`define NOISE_EST_DEFINES_SVH

// Pixel word and one colour channel
`define NE_PIX_W 32
`define NE_CH_W 8

// Variance and noise result, twice the channel width
`define NE_VAR_W 16

// 64 luma samples per block
`define NE_BLK_SHIFT 6

// Receive FIFO entries, also the sender's starting credit count
`define NE_FIFO_DEPTH 4

// blocks_per_frame and completed frame counter
`define NE_CNT_W 16

`endif

// File: verilog/noise_est_pkg.sv
// Shared types for the noise estimator.
// The pixel word is read either as one raw word or as pad/r/g/b bytes.

`include "noise_est_defines.svh"

package noise_est_pkg;

	// Blue sits in the low byte, pad in the high byte
	typedef struct packed {
		logic [`NE_CH_W-1:0] pad;
		logic [`NE_CH_W-1:0] r;
		logic [`NE_CH_W-1:0] g;
		logic [`NE_CH_W-1:0] b;
	} rgb_t;

	// Storage uses raw, the luma path uses ch
	typedef union packed {
		logic [`NE_PIX_W-1:0] raw;
		rgb_t                 ch;
	} pixel_t;

endpackage

// File: verilog/block_stats_if.sv
// Per-block results from block_stats to noise_estimator.
// No back-pressure; the sink takes every valid pulse.

`include "noise_est_defines.svh"

interface block_stats_if;

	logic                 valid;
	logic [`NE_CH_W-1:0]  mean;
	logic [`NE_VAR_W-1:0] variance;
	// Block opened with a frame start
	logic                 first;

	modport src (
		output valid,
		output mean,
		output variance,
		output first
	);

	modport snk (
		input valid,
		input mean,
		input variance,
		input first
	);

endinterface

// File: verilog/credit_rx_fifo.sv
// Receive FIFO on the pixel input with credit return.
// Pops whenever it holds an entry and pulses credit one cycle after each pop.

`include "noise_est_defines.svh"

module credit_rx_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  noise_est_pkg::pixel_t in_data,
	input  logic                  in_sof,
	output logic                  out_valid,
	output noise_est_pkg::pixel_t out_data,
	output logic                  out_sof,
	output logic                  credit
);

	localparam int DEPTH = `NE_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`NE_PIX_W-1:0] pix_mem [DEPTH];
	logic [DEPTH-1:0]     sof_mem;
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 push;
	logic                 pop;
	logic                 full;

	assign push      = in_valid;
	assign pop       = (count != '0);
	assign full      = (count == CNT_W'(DEPTH));
	assign out_valid = pop;
	assign out_sof   = sof_mem[rd_ptr];

	always_comb begin
		out_data.raw = pix_mem[rd_ptr];
	end

	// Entry storage
	always_ff @(posedge clk) begin
		if (push) begin
			pix_mem[wr_ptr] <= in_data.raw;
			sof_mem[wr_ptr] <= in_sof;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// One credit back per entry drained
			credit <= pop;
		end
	end

	// Sender spent a credit it did not have
	assert property (@(posedge clk) disable iff (!rst_n) !(in_valid && full))
		else $error("credit_rx_fifo: push into a full FIFO");

endmodule

// File: verilog/block_stats.sv
// Luma per pixel, then mean and variance over every 64 consecutive samples.
// One result pulse per block, a cycle after its last sample.
// A pixel flagged sof starts a new block.

`include "noise_est_defines.svh"

module block_stats (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  noise_est_pkg::pixel_t in_data,
	input  logic                  in_sof,
	block_stats_if.src            stats
);

	localparam int RGB_W = `NE_CH_W + 2;
	localparam int SUM_W = `NE_CH_W + `NE_BLK_SHIFT;
	localparam int SQ_W  = 2 * `NE_CH_W + `NE_BLK_SHIFT;

	logic [RGB_W-1:0]         rgb_sum;
	logic [RGB_W-1:0]         luma_full;
	logic [`NE_CH_W-1:0]      luma;
	logic [2*`NE_CH_W-1:0]    luma_sq;
	logic [`NE_BLK_SHIFT-1:0] sample_cnt;
	logic [`NE_BLK_SHIFT-1:0] sample_idx;
	logic                     block_start;
	logic                     block_end;
	logic                     block_first;
	logic [SUM_W-1:0]         sum_q;
	logic [SUM_W-1:0]         sum_next;
	logic [SQ_W-1:0]          sq_q;
	logic [SQ_W-1:0]          sq_next;
	logic [`NE_CH_W-1:0]      mean_next;
	logic [`NE_VAR_W-1:0]     mean_sq;
	logic [`NE_VAR_W-1:0]     sq_avg;

	// Luma is the channel mean, rounded down
	always_comb begin
		rgb_sum   = RGB_W'(in_data.ch.r) + RGB_W'(in_data.ch.g) + RGB_W'(in_data.ch.b);
		luma_full = rgb_sum / RGB_W'(3);
		luma      = luma_full[`NE_CH_W-1:0];
		luma_sq   = luma * luma;
	end

	// Position of this sample inside its block
	assign sample_idx  = in_sof ? '0 : sample_cnt;
	assign block_start = (sample_idx == '0);
	assign block_end   = &sample_idx;

	always_comb begin
		sum_next  = (block_start ? '0 : sum_q) + SUM_W'(luma);
		sq_next   = (block_start ? '0 : sq_q) + SQ_W'(luma_sq);
		mean_next = sum_next[SUM_W-1:`NE_BLK_SHIFT];
		sq_avg    = sq_next[SQ_W-1:`NE_BLK_SHIFT];
		mean_sq   = mean_next * mean_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt  <= '0;
			block_first <= 1'b0;
			stats.valid <= 1'b0;
		end else begin
			stats.valid <= in_valid && block_end;
			if (in_valid) begin
				sample_cnt <= sample_idx + 1'b1;
				if (block_start)
					block_first <= in_sof;
			end
		end
	end

	// Accumulators restart on every block, results held until the next one
	always_ff @(posedge clk) begin
		if (in_valid) begin
			sum_q <= sum_next;
			sq_q  <= sq_next;
			if (block_end) begin
				stats.mean     <= mean_next;
				// floor(E[x^2]) is never below floor(E[x])^2
				stats.variance <= sq_avg - mean_sq;
				stats.first    <= block_first;
			end
		end
	end

	// Frame starts must line up with block starts
	assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_sof |-> sample_cnt == '0)
		else $error("block_stats: sof in the middle of a block");

endmodule

// File: verilog/noise_estimator.sv
// Smallest block variance over one frame, taken as the noise estimate.
// blocks_per_frame is sampled at each frame's first block.
// Blocks between a finished frame and the next first block are dropped.

`include "noise_est_defines.svh"

module noise_estimator (
	input  logic                 clk,
	input  logic                 rst_n,
	block_stats_if.snk           stats,
	input  logic [`NE_CNT_W-1:0] blocks_per_frame,
	output logic                 noise_valid,
	output logic [`NE_VAR_W-1:0] noise_value
);

	logic [`NE_CNT_W-1:0] bpf_q;
	logic [`NE_CNT_W-1:0] bpf_eff;
	logic [`NE_CNT_W-1:0] blk_cnt;
	logic [`NE_CNT_W-1:0] cnt_next;
	logic [`NE_VAR_W-1:0] min_q;
	logic [`NE_VAR_W-1:0] min_next;
	logic                 active;
	logic                 start;
	logic                 take;
	logic                 last;

	always_comb begin
		start    = stats.valid && stats.first;
		take     = stats.valid && (start || active);
		cnt_next = start ? `NE_CNT_W'(1) : blk_cnt + 1'b1;
		bpf_eff  = start ? blocks_per_frame : bpf_q;
		min_next = (start || stats.variance < min_q) ? stats.variance : min_q;
		last     = take && (cnt_next == bpf_eff);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active      <= 1'b0;
			blk_cnt     <= '0;
			bpf_q       <= '0;
			noise_valid <= 1'b0;
		end else begin
			noise_valid <= last;
			if (start)
				bpf_q <= blocks_per_frame;
			if (take) begin
				blk_cnt <= cnt_next;
				active  <= !last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			min_q <= min_next;
		if (last)
			noise_value <= min_next;
	end

	// A zero block count would keep the frame open for good
	assert property (@(posedge clk) disable iff (!rst_n) start |=> bpf_q != '0)
		else $error("noise_estimator: blocks_per_frame latched as zero");

endmodule

// File: verilog/noise_regs.sv
// Configuration and status registers on a small read/write port.
// 0 blocks_per_frame (r/w), 1 last noise estimate, 2 completed frames.
// Read data comes back with cfg_rvalid one cycle after cfg_rd.

`include "noise_est_defines.svh"

module noise_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cfg_wr,
	input  logic                 cfg_rd,
	input  logic [1:0]           cfg_addr,
	input  logic [`NE_CNT_W-1:0] cfg_wdata,
	input  logic                 noise_valid,
	input  logic [`NE_VAR_W-1:0] noise_value,
	output logic [`NE_CNT_W-1:0] cfg_rdata,
	output logic                 cfg_rvalid,
	output logic [`NE_CNT_W-1:0] blocks_per_frame
);

	localparam logic [1:0] ADDR_BPF   = 2'd0;
	localparam logic [1:0] ADDR_NOISE = 2'd1;
	localparam logic [1:0] ADDR_FRAME = 2'd2;

	logic [`NE_VAR_W-1:0] last_noise;
	logic [`NE_CNT_W-1:0] frame_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blocks_per_frame <= `NE_CNT_W'(4);
			last_noise       <= '0;
			frame_cnt        <= '0;
			cfg_rvalid       <= 1'b0;
			cfg_rdata        <= '0;
		end else begin
			// Only address 0 is writable
			if (cfg_wr && cfg_addr == ADDR_BPF)
				blocks_per_frame <= cfg_wdata;
			if (noise_valid) begin
				last_noise <= noise_value;
				frame_cnt  <= frame_cnt + 1'b1;
			end
			cfg_rvalid <= cfg_rd;
			if (cfg_rd) begin
				case (cfg_addr)
					ADDR_BPF:   cfg_rdata <= blocks_per_frame;
					ADDR_NOISE: cfg_rdata <= last_noise;
					ADDR_FRAME: cfg_rdata <= frame_cnt;
					default:    cfg_rdata <= '0;
				endcase
			end
		end
	end

endmodule

// File: verilog/noise_est_top.sv
// Noise estimator top level.
// Pixels enter through the credit FIFO, block results and the
// per-frame noise estimate leave on plain ports.

`include "noise_est_defines.svh"

module noise_est_top (
	input  logic                 clk,
	input  logic                 rst_n,

	// Pixel stream, credit based
	input  logic                 pix_valid,
	input  logic [`NE_PIX_W-1:0] pix_data,
	input  logic                 pix_sof,
	output logic                 pix_credit,

	// Register port
	input  logic                 cfg_wr,
	input  logic                 cfg_rd,
	input  logic [1:0]           cfg_addr,
	input  logic [`NE_CNT_W-1:0] cfg_wdata,
	output logic [`NE_CNT_W-1:0] cfg_rdata,
	output logic                 cfg_rvalid,

	// Results
	output logic                 block_valid,
	output logic [`NE_CH_W-1:0]  block_mean,
	output logic [`NE_VAR_W-1:0] block_var,
	output logic                 noise_valid,
	output logic [`NE_VAR_W-1:0] noise_value
);

	noise_est_pkg::pixel_t fifo_data;
	logic                  fifo_valid;
	logic                  fifo_sof;
	logic [`NE_CNT_W-1:0]  blocks_per_frame;

	block_stats_if stats ();

	credit_rx_fifo credit_rx_fifo_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (pix_valid),
		.in_data   (pix_data),
		.in_sof    (pix_sof),
		.out_valid (fifo_valid),
		.out_data  (fifo_data),
		.out_sof   (fifo_sof),
		.credit    (pix_credit)
	);

	block_stats block_stats_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (fifo_valid),
		.in_data  (fifo_data),
		.in_sof   (fifo_sof),
		.stats    (stats.src)
	);

	noise_estimator noise_estimator_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.stats            (stats.snk),
		.blocks_per_frame (blocks_per_frame),
		.noise_valid      (noise_valid),
		.noise_value      (noise_value)
	);

	noise_regs noise_regs_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.cfg_wr           (cfg_wr),
		.cfg_rd           (cfg_rd),
		.cfg_addr         (cfg_addr),
		.cfg_wdata        (cfg_wdata),
		.noise_valid      (noise_valid),
		.noise_value      (noise_value),
		.cfg_rdata        (cfg_rdata),
		.cfg_rvalid       (cfg_rvalid),
		.blocks_per_frame (blocks_per_frame)
	);

	// Block results also go out on the top ports
	assign block_valid = stats.valid;
	assign block_mean  = stats.mean;
	assign block_var   = stats.variance;

endmodule

// File: tb/noise_est_tb.sv
// Directed testbench for the noise estimator top level.
// A credit-keeping driver feeds pixels, a reference model queues the expected
// block and frame results, and a monitor compares them as they come out.

`include "noise_est_defines.svh"

module noise_est_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = `NE_FIFO_DEPTH;
	localparam int BLK = 1 << `NE_BLK_SHIFT;
	// Blocks over all tests: 4 + 4 + 4 + (4 + 2)
	localparam int TOTAL_PIX = 18 * BLK;
	localparam int TIMEOUT = 3 * TOTAL_PIX + 1000;

	logic        clk;
	logic        rst_n;
	logic        pix_valid;
	logic [31:0] pix_data;
	logic        pix_sof;
	logic        pix_credit;
	logic        cfg_wr;
	logic        cfg_rd;
	logic [1:0]  cfg_addr;
	logic [15:0] cfg_wdata;
	logic [15:0] cfg_rdata;
	logic        cfg_rvalid;
	logic        block_valid;
	logic [7:0]  block_mean;
	logic [15:0] block_var;
	logic        noise_valid;
	logic [15:0] noise_value;

	// Driver and monitor state
	int credits = DEPTH;
	int sent = 0;
	int returned = 0;
	int cycles = 0;
	int blocks_since_noise = 0;

	// Reference model state
	int samp_cnt = 0;
	int sum = 0;
	int sumsq = 0;
	int frame_blk = 0;
	int frame_bpf = 0;
	int frame_min = 0;
	bit frame_open = 0;
	int model_bpf = 4;
	int frames_done = 0;
	int last_noise = 0;
	int exp_mean[$];
	int exp_var[$];
	int exp_noise[$];
	int exp_noise_blk[$];

	noise_est_top noise_est_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.pix_sof     (pix_sof),
		.pix_credit  (pix_credit),
		.cfg_wr      (cfg_wr),
		.cfg_rd      (cfg_rd),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.cfg_rvalid  (cfg_rvalid),
		.block_valid (block_valid),
		.block_mean  (block_mean),
		.block_var   (block_var),
		.noise_valid (noise_valid),
		.noise_value (noise_value)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT)
			fail_run($sformatf("The run hung: still busy after %0d cycles", cycles));
	end

	// Outputs are registered, so they are sampled half a cycle later
	always @(negedge clk) begin
		if (rst_n) begin
			if (pix_credit) begin
				credits++;
				returned++;
				if (credits > DEPTH)
					fail_run("More credits came back than the FIFO can hold");
			end
			if (block_valid) begin
				if (exp_mean.size() == 0) begin
					fail_run("A block result arrived when none was expected");
				end else begin
					check_value("block_mean", block_mean, exp_mean.pop_front());
					check_value("block_var", block_var, exp_var.pop_front());
					blocks_since_noise++;
				end
			end
			if (noise_valid) begin
				if (exp_noise.size() == 0) begin
					fail_run("A noise result arrived when none was expected");
				end else begin
					check_value("noise_value", noise_value, exp_noise.pop_front());
					check_value("noise_block_count", blocks_since_noise,
						exp_noise_blk.pop_front());
					blocks_since_noise = 0;
				end
			end
		end
	end

	function automatic int luma_of(input logic [31:0] pix);
		return (int'(pix[23:16]) + int'(pix[15:8]) + int'(pix[7:0])) / 3;
	endfunction

	// Block mean, variance and frame minimum straight from the definitions
	task automatic model_pixel(input logic [31:0] pix, input logic sof);
		int y;
		int mean;
		int variance;
		y = luma_of(pix);
		if (sof) begin
			samp_cnt = 0;
			frame_open = 1;
			frame_blk = 0;
			frame_bpf = model_bpf;
		end
		if (samp_cnt == 0) begin
			sum = 0;
			sumsq = 0;
		end
		sum += y;
		sumsq += y * y;
		samp_cnt++;
		if (samp_cnt == BLK) begin
			samp_cnt = 0;
			mean = sum / BLK;
			variance = sumsq / BLK - mean * mean;
			exp_mean.push_back(mean);
			exp_var.push_back(variance);
			if (frame_open) begin
				frame_blk++;
				if (frame_blk == 1 || variance < frame_min)
					frame_min = variance;
				if (frame_blk == frame_bpf) begin
					exp_noise.push_back(frame_min);
					exp_noise_blk.push_back(frame_bpf);
					frame_open = 0;
					frames_done++;
					last_noise = frame_min;
				end
			end
		end
	endtask

	task automatic send_pixel(input logic [31:0] pix, input logic sof);
		while (credits == 0) begin
			@(posedge clk);
			#1;
		end
		pix_valid = 1'b1;
		pix_data = pix;
		pix_sof = sof;
		credits--;
		sent++;
		model_pixel(pix, sof);
		@(posedge clk);
		#1;
		pix_valid = 1'b0;
		pix_sof = 1'b0;
	endtask

	// Last pixel of a burst is popped a cycle after its push, its credit a cycle later
	task automatic check_credit_return(input int ret0);
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		check_value("pix_credit_count", returned - ret0, DEPTH);
	endtask

	// Paced blocks go out in bursts of DEPTH pixels, each burst's credits checked
	task automatic send_block(input bit sof, input bit rand_pix,
		input logic [31:0] flat_pix, input bit paced);
		logic [31:0] pix;
		int ret0;
		for (int i = 0; i < BLK; i++) begin
			if (paced && (i % DEPTH) == 0)
				ret0 = returned;
			pix = rand_pix ? $urandom : flat_pix;
			send_pixel(pix, sof && i == 0);
			if (paced && (i % DEPTH) == DEPTH - 1)
				check_credit_return(ret0);
		end
	endtask

	task automatic wait_idle();
		while (exp_mean.size() != 0 || exp_noise.size() != 0 || credits != DEPTH) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
		if (addr == 2'd0)
			model_bpf = data;
	endtask

	task automatic check_reg(input logic [1:0] addr, input int exp, input string name);
		cfg_rd = 1'b1;
		cfg_addr = addr;
		@(posedge clk);
		#1;
		cfg_rd = 1'b0;
		if (!cfg_rvalid)
			fail_run("No read response one cycle after cfg_rd");
		else
			check_value(name, cfg_rdata, exp);
	endtask

	task automatic test_reset_regs();
		check_value("pix_credit", pix_credit, 0);
		check_value("block_valid", block_valid, 0);
		check_value("noise_valid", noise_valid, 0);
		check_value("cfg_rvalid", cfg_rvalid, 0);
		check_reg(2'd0, 4, "blocks_per_frame");
		write_reg(2'd0, 16'h0009);
		check_reg(2'd0, 9, "blocks_per_frame");
		// Read-only address must ignore the write
		write_reg(2'd1, 16'h1234);
		check_reg(2'd1, 0, "last_noise");
		write_reg(2'd0, 16'h0004);
		check_reg(2'd0, 4, "blocks_per_frame");
	endtask

	task automatic test_flat_frame();
		for (int b = 0; b < 4; b++)
			send_block(b == 0, 1'b0, 32'h5a40_80c0, 1'b0);
		wait_idle();
	endtask

	task automatic test_random_frame();
		for (int b = 0; b < 4; b++)
			send_block(b == 0, 1'b1, 32'h0, 1'b0);
		wait_idle();
	endtask

	task automatic test_credit_pacing();
		for (int b = 0; b < 4; b++)
			send_block(b == 0, 1'b1, 32'h0, 1'b1);
		wait_idle();
	endtask

	// Frame in flight keeps 4 blocks, the following frame uses 2
	task automatic test_reconfig();
		send_block(1'b1, 1'b1, 32'h0, 1'b0);
		send_block(1'b0, 1'b1, 32'h0, 1'b0);
		write_reg(2'd0, 16'h0002);
		send_block(1'b0, 1'b1, 32'h0, 1'b0);
		send_block(1'b0, 1'b1, 32'h0, 1'b0);
		send_block(1'b1, 1'b1, 32'h0, 1'b0);
		send_block(1'b0, 1'b1, 32'h0, 1'b0);
		wait_idle();
	endtask

	task automatic test_status_regs();
		check_reg(2'd1, last_noise, "last_noise");
		check_reg(2'd2, frames_done, "frame_count");
	endtask

	initial begin
		void'($urandom(32'hfa0c_d497));
		rst_n = 1'b0;
		pix_valid = 1'b0;
		pix_data = '0;
		pix_sof = 1'b0;
		cfg_wr = 1'b0;
		cfg_rd = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		test_reset_regs();
		test_flat_frame();
		test_random_frame();
		test_credit_pacing();
		test_reconfig();
		test_status_regs();
		if (exp_mean.size() != 0 || exp_noise.size() != 0) begin
			fail_run("Expected results never arrived");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: noise_est.f
+incdir+verilog
verilog/noise_est_pkg.sv
verilog/block_stats_if.sv
verilog/credit_rx_fifo.sv
verilog/block_stats.sv
verilog/noise_estimator.sv
verilog/noise_regs.sv
verilog/noise_est_top.sv
tb/noise_est_tb.sv

// File: Bender.yml
package:
  name: noise_est

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/noise_est_pkg.sv
      - verilog/block_stats_if.sv
      - verilog/credit_rx_fifo.sv
      - verilog/block_stats.sv
      - verilog/noise_estimator.sv
      - verilog/noise_regs.sv
      - verilog/noise_est_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/noise_est_tb.sv
